//--- Bender.yml
package:
  name: csr_unit

sources:
  - design/csr_pkg.sv
  - design/csr_decode.sv
  - design/csr_alu.sv
  - design/csr_regfile.sv
  - design/csr_unit.sv
  - target: test
    files:
      - dv/csr_unit_assert.sv
      - dv/csr_unit_tb.sv

//--- design/csr_alu.sv
`timescale 1ns/10ps

module csr_alu (
    input  csr_pkg::csr_req_t req,
    input  csr_pkg::xlen_t    old_value,
    input  csr_pkg::xlen_t    rs1_data,
    output csr_pkg::xlen_t    new_value
);

    csr_pkg::xlen_t src;

    assign src = req.use_imm ? csr_pkg::xlen_t'(req.zimm) : rs1_data;  // zimm zero extended

    always_comb begin
        case (req.op)
            csr_pkg::WRITE: new_value = src;
            csr_pkg::SET:   new_value = old_value | src;
            csr_pkg::CLEAR: new_value = old_value & ~src;
            default:        new_value = csr_pkg::BAD_CSR_READ;
        endcase
    end

endmodule

//--- design/csr_decode.sv
`timescale 1ns/10ps

module csr_decode (
    input  logic               instr_valid,
    input  csr_pkg::insn_t     instr,
    output csr_pkg::csr_req_t  req,
    output csr_pkg::trap_req_t trap
);

    logic [6:0]         opcode;
    logic [4:0]         rd;
    logic [2:0]         funct3;
    logic [4:0]         rs1;
    csr_pkg::csr_addr_t csr;
    logic               is_system;
    logic               is_priv;
    logic               is_ecall;
    logic               is_mret;

    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];         // doubles as zimm
    assign csr    = instr[31:20];

    assign is_system = instr_valid && (opcode == csr_pkg::OPCODE_SYSTEM);
    assign is_priv   = is_system && (funct3 == csr_pkg::FUNCT3_PRIV)
                       && (rs1 == 5'd0) && (rd == 5'd0);
    assign is_ecall  = is_priv && (csr == csr_pkg::FUNCT12_ECALL);
    assign is_mret   = is_priv && (csr == csr_pkg::FUNCT12_MRET);

    always_comb begin
        req         = '0;
        req.op      = csr_pkg::NONE;
        req.addr    = csr;
        req.zimm    = rs1;
        req.use_imm = funct3[2];
        if (is_system) begin
            case (funct3[1:0])
                2'b01:   req.op = csr_pkg::WRITE;
                2'b10:   req.op = csr_pkg::SET;
                2'b11:   req.op = csr_pkg::CLEAR;
                default: req.op = csr_pkg::NONE;  // ecall, mret, others
            endcase
        end
        req.valid = (req.op != csr_pkg::NONE);

        // x0 rules
        case (req.op)
            csr_pkg::WRITE: begin
                req.wen   = 1'b1;
                req.rd_en = (rd != 5'd0);
            end
            csr_pkg::SET, csr_pkg::CLEAR: begin
                req.wen   = (rs1 != 5'd0);    // nothing to set or clear
                req.rd_en = 1'b1;
            end
            default: begin
                req.wen   = 1'b0;
                req.rd_en = 1'b0;
            end
        endcase
    end

    always_comb begin
        trap.ret   = is_mret;
        trap.raise = is_ecall;
        trap.cause = is_ecall ? csr_pkg::CAUSE_ECALL_M : '0;
    end

endmodule

//--- design/csr_pkg.sv
package csr_pkg;

    typedef logic [63:0] xlen_t;     // data word, pc, csr value
    typedef logic [31:0] insn_t;
    typedef logic [11:0] csr_addr_t;

    // encoding follows funct3[1:0] of the zicsr forms
    typedef enum logic [1:0] {
        NONE  = 2'b00,
        WRITE = 2'b01,
        SET   = 2'b10,
        CLEAR = 2'b11
    } csr_op_e;

    typedef struct packed {
        logic      valid;
        csr_op_e   op;
        logic      use_imm;
        logic [4:0] zimm;
        csr_addr_t addr;
        logic      wen;              // csr gets written
        logic      rd_en;            // rd gets old value
    } csr_req_t;

    typedef struct packed {
        logic  raise;
        logic  ret;
        xlen_t cause;
    } trap_req_t;

    localparam csr_addr_t CSR_MSTATUS = 12'h300;
    localparam csr_addr_t CSR_MTVEC   = 12'h305;
    localparam csr_addr_t CSR_MEPC    = 12'h341;
    localparam csr_addr_t CSR_MCAUSE  = 12'h342;

    localparam int MSTATUS_MIE    = 3;
    localparam int MSTATUS_MPIE   = 7;
    localparam int MSTATUS_MPP_LO = 11;

    localparam xlen_t CAUSE_ILLEGAL_INSN = 64'd2;
    localparam xlen_t CAUSE_ECALL_M      = 64'd11;

    localparam logic [6:0]  OPCODE_SYSTEM = 7'h73;
    localparam logic [2:0]  FUNCT3_PRIV   = 3'b000;
    localparam logic [11:0] FUNCT12_ECALL = 12'h000;
    localparam logic [11:0] FUNCT12_MRET  = 12'h302;

    localparam xlen_t BAD_CSR_READ = 64'h114514;

endpackage

//--- design/csr_regfile.sv
`timescale 1ns/10ps

module csr_regfile #(
    parameter csr_pkg::xlen_t MSTATUS_RESET = 64'ha0001800
) (
    input  logic               clk,
    input  logic               rst,
    input  csr_pkg::csr_req_t  req,
    input  csr_pkg::trap_req_t trap,
    input  logic               bad_access,
    input  csr_pkg::xlen_t     wdata,
    input  csr_pkg::xlen_t     pc,
    output csr_pkg::xlen_t     rdata,
    output logic               addr_err,
    output logic               jmp,
    output csr_pkg::xlen_t     nxtpc
);

    csr_pkg::xlen_t mstatus;
    csr_pkg::xlen_t mepc;
    csr_pkg::xlen_t mcause;
    csr_pkg::xlen_t mtvec;
    logic           known;
    logic           do_write;
    logic           do_raise;

    always_comb begin
        known = 1'b1;
        case (req.addr)
            csr_pkg::CSR_MSTATUS: rdata = mstatus;
            csr_pkg::CSR_MTVEC:   rdata = mtvec;
            csr_pkg::CSR_MEPC:    rdata = mepc;
            csr_pkg::CSR_MCAUSE:  rdata = mcause;
            default: begin
                rdata = csr_pkg::BAD_CSR_READ;
                known = 1'b0;
            end
        endcase
    end

    assign addr_err = req.valid && req.wen && !known;

    assign do_write = req.wen && !bad_access;
    assign do_raise = trap.raise || bad_access;  // illegal access traps too

    assign jmp   = trap.ret || do_raise;
    assign nxtpc = trap.ret ? mepc : mtvec;

    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus <= MSTATUS_RESET;
            mepc    <= '0;
            mcause  <= '0;
            mtvec   <= '0;
        end else if (trap.ret) begin
            mstatus[csr_pkg::MSTATUS_MPP_LO +: 2] <= 2'b00;
            mstatus[csr_pkg::MSTATUS_MIE]         <= mstatus[csr_pkg::MSTATUS_MPIE];
            mstatus[csr_pkg::MSTATUS_MPIE]        <= 1'b1;
        end else if (do_write) begin
            case (req.addr)
                csr_pkg::CSR_MSTATUS: mstatus <= wdata;
                csr_pkg::CSR_MTVEC:   mtvec   <= wdata;
                csr_pkg::CSR_MEPC:    mepc    <= wdata;
                csr_pkg::CSR_MCAUSE:  mcause  <= wdata;
                default: ;
            endcase
        end else if (do_raise) begin
            mcause <= bad_access ? csr_pkg::CAUSE_ILLEGAL_INSN : trap.cause;
            mepc   <= pc;
            mstatus[csr_pkg::MSTATUS_MPP_LO +: 2] <= 2'b11;  // back to M
            mstatus[csr_pkg::MSTATUS_MPIE]        <= mstatus[csr_pkg::MSTATUS_MIE];
            mstatus[csr_pkg::MSTATUS_MIE]         <= 1'b0;
        end
    end

endmodule

//--- design/csr_unit.sv
`timescale 1ns/10ps

module csr_unit #(
    parameter csr_pkg::xlen_t MSTATUS_RESET = 64'ha0001800
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           instr_valid,
    input  csr_pkg::insn_t instr,
    input  csr_pkg::xlen_t rs1_data,
    input  csr_pkg::xlen_t pc,
    output csr_pkg::xlen_t rd_data,
    output logic           rd_wen,
    output logic           illegal,
    output logic           jmp,
    output csr_pkg::xlen_t nxtpc
);

    csr_pkg::csr_req_t  req;
    csr_pkg::trap_req_t trap;
    csr_pkg::xlen_t     csr_rdata;
    csr_pkg::xlen_t     wdata;
    logic               addr_err;

    csr_decode i_decode (
        .instr_valid (instr_valid),
        .instr       (instr),
        .req         (req),
        .trap        (trap)
    );

    csr_alu i_alu (
        .req       (req),
        .old_value (csr_rdata),
        .rs1_data  (rs1_data),
        .new_value (wdata)
    );

    // addr_err loops back as bad_access to raise the illegal trap
    csr_regfile #(
        .MSTATUS_RESET (MSTATUS_RESET)
    ) i_regfile (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .trap       (trap),
        .bad_access (addr_err),
        .wdata      (wdata),
        .pc         (pc),
        .rdata      (csr_rdata),
        .addr_err   (addr_err),
        .jmp        (jmp),
        .nxtpc      (nxtpc)
    );

    assign rd_data = csr_rdata;
    assign rd_wen  = req.rd_en && !addr_err;  // illegal access drops rd
    assign illegal = addr_err;

endmodule

//--- dv/csr_unit_assert.sv
`timescale 1ns/10ps

module csr_unit_assert (
    input logic           clk,
    input logic           rst,
    input logic           instr_valid,
    input csr_pkg::insn_t instr,
    input logic           rd_wen,
    input logic           illegal,
    input logic           jmp
);

    int unsigned fail_count = 0;

    logic sys;
    logic csr_access;
    logic writes;
    logic known;
    logic bad;
    logic ecall_or_mret;

    assign sys        = instr_valid && (instr[6:0] == csr_pkg::OPCODE_SYSTEM);
    assign csr_access = sys && (instr[13:12] != 2'b00);
    assign writes     = (instr[13:12] == 2'b01) || (instr[19:15] != 5'd0);
    assign known      = instr[31:20] inside {csr_pkg::CSR_MSTATUS, csr_pkg::CSR_MTVEC,
                                             csr_pkg::CSR_MEPC, csr_pkg::CSR_MCAUSE};
    assign bad        = csr_access && writes && !known;
    assign ecall_or_mret = instr_valid && (instr == 32'h0000_0073 || instr == 32'h3020_0073);

    quiet_when_idle: assert property (@(posedge clk) disable iff (rst)
        !instr_valid |-> (!jmp && !rd_wen && !illegal))
        else begin $error("strobe active without a valid instruction"); fail_count++; end

    jmp_rule: assert property (@(posedge clk) disable iff (rst)
        jmp == (ecall_or_mret || bad))
        else begin $error("jmp does not match ecall, mret or illegal access"); fail_count++; end

    illegal_rule: assert property (@(posedge clk) disable iff (rst)
        illegal == bad)
        else begin $error("illegal does not match a write to an unknown csr"); fail_count++; end

    // csrrw to x0 skips rd, an illegal access drops it too
    rd_wen_rule: assert property (@(posedge clk) disable iff (rst)
        rd_wen == (csr_access && !bad && (instr[13:12] != 2'b01 || instr[11:7] != 5'd0)))
        else begin $error("rd_wen does not follow the x0 and illegal rules"); fail_count++; end

endmodule

//--- dv/csr_unit_tb.sv
`timescale 1ns/10ps

module csr_unit_tb;

    localparam csr_pkg::xlen_t MSTATUS_RESET = 64'ha0001800;
    localparam int N_INSNS    = 120;                        // upper bound of issued instructions
    localparam int TIMEOUT_NS = (N_INSNS + 30) * 100 + 2000; // reset and idle cycles plus margin

    logic           clk = 1'b0;
    logic           rst;
    logic           instr_valid;
    csr_pkg::insn_t instr;
    csr_pkg::xlen_t rs1_data;
    csr_pkg::xlen_t pc;
    csr_pkg::xlen_t rd_data;
    logic           rd_wen;
    logic           illegal;
    logic           jmp;
    csr_pkg::xlen_t nxtpc;

    integer seed = 48;
    int     checks = 0;
    int     errors = 0;
    int     issued = 0;
    int     test_errors;
    int     test_asserts;

    csr_pkg::xlen_t     m_mstatus, m_mepc, m_mcause, m_mtvec;  // expected csr contents
    csr_pkg::csr_addr_t csr_list [4];
    logic [2:0]         op_list [6];

    always #50 clk = ~clk;

    csr_unit #(
        .MSTATUS_RESET (MSTATUS_RESET)
    ) i_dut (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .rs1_data    (rs1_data),
        .pc          (pc),
        .rd_data     (rd_data),
        .rd_wen      (rd_wen),
        .illegal     (illegal),
        .jmp         (jmp),
        .nxtpc       (nxtpc)
    );

    bind csr_unit csr_unit_assert i_assert (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .rd_wen      (rd_wen),
        .illegal     (illegal),
        .jmp         (jmp)
    );

    function automatic csr_pkg::insn_t csr_insn(input logic [2:0] funct3,
            input csr_pkg::csr_addr_t addr, input logic [4:0] rs1, input logic [4:0] rd);
        return {addr, rs1, funct3, rd, 7'h73};
    endfunction

    function automatic csr_pkg::xlen_t random64();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic bit is_known(input csr_pkg::csr_addr_t addr);
        return addr inside {12'h300, 12'h305, 12'h341, 12'h342};
    endfunction

    function automatic csr_pkg::xlen_t model_read(input csr_pkg::csr_addr_t addr);
        case (addr)
            12'h300: return m_mstatus;
            12'h305: return m_mtvec;
            12'h341: return m_mepc;
            12'h342: return m_mcause;
            default: return 64'h114514;
        endcase
    endfunction

    task automatic model_write(input csr_pkg::csr_addr_t addr, input csr_pkg::xlen_t value);
        case (addr)
            12'h300: m_mstatus = value;
            12'h305: m_mtvec   = value;
            12'h341: m_mepc    = value;
            12'h342: m_mcause  = value;
            default: ;
        endcase
    endtask

    task automatic model_trap(input csr_pkg::xlen_t cause, input csr_pkg::xlen_t pcv);
        m_mcause         = cause;
        m_mepc           = pcv;
        m_mstatus[12:11] = 2'b11;
        m_mstatus[7]     = m_mstatus[3];  // mie into mpie
        m_mstatus[3]     = 1'b0;
    endtask

    task automatic model_mret();
        m_mstatus[12:11] = 2'b00;
        m_mstatus[3]     = m_mstatus[7];
        m_mstatus[7]     = 1'b1;
    endtask

    task automatic check_value(input csr_pkg::xlen_t got, input csr_pkg::xlen_t exp,
            input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic drive(input csr_pkg::insn_t insn, input csr_pkg::xlen_t rs1v,
            input csr_pkg::xlen_t pcv);
        @(negedge clk);
        instr_valid = 1'b1;
        instr       = insn;
        rs1_data    = rs1v;
        pc          = pcv;
        issued++;
        #20;  // outputs settled, well before the next rising edge
    endtask

    task automatic run_csr(input logic [2:0] funct3, input csr_pkg::csr_addr_t addr,
            input logic [4:0] rs1, input logic [4:0] rd, input csr_pkg::xlen_t rs1v);
        csr_pkg::xlen_t old_v;
        csr_pkg::xlen_t src;
        csr_pkg::xlen_t pcv;
        bit             writes;
        pcv    = random64() & ~64'h3;
        old_v  = model_read(addr);
        src    = funct3[2] ? {59'd0, rs1} : rs1v;
        writes = (funct3[1:0] == 2'b01) || (rs1 != 5'd0);
        drive(csr_insn(funct3, addr, rs1, rd), rs1v, pcv);
        check_value(rd_data, old_v, $sformatf("old value of csr %h", addr));
        if (writes && !is_known(addr)) begin
            check_value(nxtpc, m_mtvec, "illegal access target");
            model_trap(64'd2, pcv);
        end else if (writes) begin
            case (funct3[1:0])
                2'b01:   model_write(addr, src);
                2'b10:   model_write(addr, old_v | src);
                default: model_write(addr, old_v & ~src);
            endcase
        end
    endtask

    task automatic run_ecall(input csr_pkg::xlen_t pcv);
        drive(32'h0000_0073, random64(), pcv);
        check_value(nxtpc, m_mtvec, "ecall target");
        model_trap(64'd11, pcv);
    endtask

    task automatic run_mret();
        drive(32'h3020_0073, random64(), random64());
        check_value(nxtpc, m_mepc, "mret target");
        model_mret();
    endtask

    task automatic begin_test();
        test_errors  = errors;
        test_asserts = i_dut.i_assert.fail_count;
    endtask

    task automatic finish_test(input string name);
        int a;
        @(negedge clk);
        instr_valid = 1'b0;
        instr       = '0;
        a = i_dut.i_assert.fail_count - test_asserts;
        if (errors == test_errors && a == 0)
            $display("test %s: ok", name);
        else
            $display("test %s: %0d value errors, %0d assertion failures", name,
                     errors - test_errors, a);
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        int k;
        int asserts;
        csr_pkg::insn_t idle_list [3];
        rst = 1'b1;
        instr_valid = 1'b0;
        instr = '0;
        rs1_data = '0;
        pc = '0;
        m_mstatus = MSTATUS_RESET;
        m_mepc = '0;
        m_mcause = '0;
        m_mtvec = '0;
        csr_list = '{12'h300, 12'h305, 12'h341, 12'h342};
        op_list  = '{3'b001, 3'b010, 3'b011, 3'b101, 3'b110, 3'b111};
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        begin_test();
        idle_list = '{32'h0000_0073, csr_insn(3'b001, 12'h7c0, 5'd3, 5'd1),
                      csr_insn(3'b010, 12'h300, 5'd0, 5'd1)};
        for (int i = 0; i < 3; i++) begin
            @(negedge clk);
            instr = idle_list[i];  // held while instr_valid stays low
            #20;
            check_value({61'd0, jmp, rd_wen, illegal}, '0, "strobes while idle");
        end
        run_csr(3'b010, 12'h300, 5'd0, 5'd1, random64());
        check_value(rd_data, MSTATUS_RESET, "mstatus after reset");
        finish_test("reset");

        begin_test();
        for (int i = 0; i < 4; i++) begin
            run_csr(3'b001, csr_list[i], 5'd5, 5'd1, random64());
            run_csr(3'b010, csr_list[i], 5'd0, 5'd2, random64());
            run_csr(3'b001, csr_list[i], 5'd6, 5'd0, random64());  // rd = x0
            run_csr(3'b010, csr_list[i], 5'd0, 5'd3, random64());
        end
        finish_test("csrrw");

        begin_test();
        for (int i = 0; i < 4; i++) begin
            run_csr(3'b010, csr_list[i], 5'd7, 5'd1, random64());
            run_csr(3'b011, csr_list[i], 5'd8, 5'd1, random64());
            run_csr(3'b110, csr_list[i], 5'h15, 5'd1, '0);
            run_csr(3'b111, csr_list[i], 5'h0c, 5'd1, '0);
            run_csr(3'b010, csr_list[i], 5'd0, 5'd1, random64());  // x0, no write
            run_csr(3'b011, csr_list[i], 5'd0, 5'd1, random64());
            run_csr(3'b110, csr_list[i], 5'd0, 5'd1, '0);
            run_csr(3'b010, csr_list[i], 5'd0, 5'd1, '0);
        end
        finish_test("set and clear");

        begin_test();
        run_csr(3'b110, 12'h300, 5'd8, 5'd1, '0);  // mie on
        run_csr(3'b001, 12'h305, 5'd9, 5'd1, random64() & ~64'h3);
        run_ecall(random64() & ~64'h3);
        run_csr(3'b010, 12'h341, 5'd0, 5'd1, '0);
        run_csr(3'b010, 12'h342, 5'd0, 5'd1, '0);
        check_value(rd_data, 64'd11, "mcause after ecall");
        run_csr(3'b010, 12'h300, 5'd0, 5'd1, '0);
        check_value({60'd0, rd_data[12:11], rd_data[7], rd_data[3]}, 64'he, "mstatus after ecall");
        finish_test("ecall");

        begin_test();
        run_csr(3'b001, 12'h341, 5'd4, 5'd1, random64() & ~64'h3);
        run_mret();
        run_csr(3'b010, 12'h300, 5'd0, 5'd1, '0);
        check_value({60'd0, rd_data[12:11], rd_data[7], rd_data[3]}, 64'h3, "mstatus after mret");
        run_csr(3'b011, 12'h300, 5'd2, 5'd1, 64'h80);  // clear mpie
        run_mret();
        run_csr(3'b010, 12'h300, 5'd0, 5'd1, '0);
        check_value({63'd0, rd_data[3]}, '0, "mie restored from cleared mpie");
        finish_test("mret");

        begin_test();
        run_csr(3'b001, 12'h7c0, 5'd3, 5'd1, random64());
        run_csr(3'b010, 12'h7c0, 5'd0, 5'd1, random64());  // read only, no trap
        check_value(rd_data, 64'h114514, "read of unknown csr");
        run_csr(3'b010, 12'h342, 5'd0, 5'd1, '0);
        check_value(rd_data, 64'd2, "mcause after illegal access");
        run_csr(3'b111, 12'hb00, 5'd1, 5'd1, '0);
        run_csr(3'b010, 12'h341, 5'd0, 5'd1, '0);
        finish_test("illegal access");

        begin_test();
        repeat (32) begin
            k = $unsigned($random(seed)) % 5;
            run_csr(op_list[$unsigned($random(seed)) % 6], (k == 4) ? 12'h7c0 : csr_list[k],
                    5'($random(seed)), 5'($random(seed)), random64());
        end
        finish_test("random");

        asserts = i_dut.i_assert.fail_count;
        $display("%0d instructions, %0d checks, %0d value errors, %0d assertion failures",
                 issued, checks, errors, asserts);
        if (errors == 0 && asserts == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- src.f
design/csr_pkg.sv
design/csr_decode.sv
design/csr_alu.sv
design/csr_regfile.sv
design/csr_unit.sv
dv/csr_unit_assert.sv
dv/csr_unit_tb.sv
